// ==== hw/swa_pkg.sv ====
package swa_pkg;

    // router size
    localparam int num_ports = 5;
    localparam int num_vcs   = 4;
    // an input never requests its own port
    localparam int num_dests = num_ports - 1;

    // one bit per vc of a port
    typedef logic [num_vcs-1:0] vc_mask_t;

    // one-hot over the other ports, own port squeezed out
    // bit k of input i means output k below i, output k+1 otherwise
    typedef logic [num_dests-1:0] dest_mask_t;

    // requested output of every vc of one port
    typedef dest_mask_t [num_vcs-1:0] vc_dest_t;

    // per input port request bundle
    typedef struct packed {
        vc_mask_t request;
        // vc already owns an output vc
        vc_mask_t ovc_assigned;
        // owned output vc has buffer space
        vc_mask_t ovc_not_full;
        // vc may try for the switch while still waiting on vc allocation
        vc_mask_t spec_valid;
        vc_dest_t dest;
    } port_req_t;

    // per input port grant bundle
    typedef struct packed {
        vc_mask_t   ivc_grant;
        dest_mask_t dest_grant;
        // grant came from the speculative allocator
        logic       spec;
    } port_grant_t;

    // whole router
    typedef port_req_t   [num_ports-1:0] req_all_t;
    typedef port_grant_t [num_ports-1:0] grant_all_t;

endpackage

// ==== hw/rr_arbiter.sv ====
`timescale 1ns/100ps

module rr_arbiter import swa_pkg::*; #(
    parameter int arb_width = num_vcs
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [arb_width-1:0] request,
    input  logic                 advance,
    output logic [arb_width-1:0] grant,
    output logic                 any_grant
);

    // one-hot pointer, its bit is the highest priority requester
    logic [arb_width-1:0] priority_ptr;
    // requests at or above the pointer position
    logic [arb_width-1:0] upper_req;
    logic [arb_width-1:0] upper_pick;
    logic [arb_width-1:0] lower_pick;
    logic [arb_width-1:0] next_ptr;

    // ptr - 1 is the thermometer of positions below the pointer
    assign upper_req = request & ~(priority_ptr - arb_width'(1));

    // lowest set bit of each half
    assign upper_pick = upper_req & (~upper_req + arb_width'(1));
    assign lower_pick = request & (~request + arb_width'(1));

    // wrap to the bottom when nothing waits above the pointer
    assign grant     = (|upper_req) ? upper_pick : lower_pick;
    assign any_grant = |request;

    // one past the winner, rotating around the top
    assign next_ptr = (grant << 1) | (grant >> (arb_width - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            // bit 0 first after reset
            priority_ptr <= arb_width'(1);
        end else if (advance && any_grant) begin
            priority_ptr <= next_ptr;
        end
    end

endmodule

// ==== hw/separable_sw_alloc.sv ====
`timescale 1ns/100ps

module separable_sw_alloc import swa_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,
    input  vc_mask_t   [num_ports-1:0]   vc_req,
    input  vc_dest_t   [num_ports-1:0]   dest,
    output vc_mask_t   [num_ports-1:0]   ivc_grant,
    output dest_mask_t [num_ports-1:0]   dest_grant,
    output logic       [num_ports-1:0]   out_busy
);

    // first stage winner per input port
    vc_mask_t   in_win   [num_ports];
    // destination of that winner
    dest_mask_t win_dest [num_ports];
    // requests and grants of each output arbiter, indexed by squeezed input
    dest_mask_t out_req  [num_ports];
    dest_mask_t out_gnt  [num_ports];
    // input port won its output
    logic [num_ports-1:0] in_granted;

    genvar i, j;

    for (i = 0; i < num_ports; i++) begin : g_in_port
        // pick one vc per input port
        // pointer moves only when the port wins its output too
        rr_arbiter #(
            .arb_width (num_vcs)
        ) input_arb (
            .clk       (clk),
            .reset     (reset),
            .request   (vc_req[i]),
            .advance   (in_granted[i]),
            .grant     (in_win[i]),
            .any_grant ()
        );

        // one-hot mux of the winner's destination
        always_comb begin
            win_dest[i] = '0;
            for (int v = 0; v < num_vcs; v++) begin
                if (in_win[i][v]) begin
                    win_dest[i] = win_dest[i] | dest[i][v];
                end
            end
        end

        // port granted when any output picked it
        assign in_granted[i] = |dest_grant[i];
        // gate the vc winner with the output result
        assign ivc_grant[i]  = in_granted[i] ? in_win[i] : '0;
    end

    // crossbar between input-relative and output-relative positions
    // i is the output port, j the input port
    for (i = 0; i < num_ports; i++) begin : g_route_out
        for (j = 0; j < num_ports; j++) begin : g_route_in
            if (j < i) begin : g_below
                // output i sits at bit i-1 for input j below it
                assign out_req[i][j]      = win_dest[j][i-1];
                assign dest_grant[j][i-1] = out_gnt[i][j];
            end else if (j > i) begin : g_above
                // input j sits at position j-1 for output i
                assign out_req[i][j-1]    = win_dest[j][i];
                assign dest_grant[j][i]   = out_gnt[i][j-1];
            end
            // j == i has no wire, no port sends to itself
        end
    end

    for (i = 0; i < num_ports; i++) begin : g_out_port
        // one input port per output, advances on every grant
        rr_arbiter #(
            .arb_width (num_dests)
        ) output_arb (
            .clk       (clk),
            .reset     (reset),
            .request   (out_req[i]),
            .advance   (out_busy[i]),
            .grant     (out_gnt[i]),
            .any_grant (out_busy[i])
        );
    end

endmodule

// ==== hw/spec_conflict_filter.sv ====
`timescale 1ns/100ps

module spec_conflict_filter import swa_pkg::*; (
    input  vc_mask_t   [num_ports-1:0] ns_ivc_grant,
    input  dest_mask_t [num_ports-1:0] ns_dest_grant,
    input  logic       [num_ports-1:0] ns_out_busy,
    input  vc_mask_t   [num_ports-1:0] sp_ivc_grant,
    input  dest_mask_t [num_ports-1:0] sp_dest_grant,
    output grant_all_t                 grant
);

    // outputs taken by the non-speculative path, seen from each input
    dest_mask_t ns_out_rel [num_ports];
    // outputs a speculative grant may still use
    dest_mask_t sp_free    [num_ports];
    dest_mask_t sp_accept  [num_ports];
    logic [num_ports-1:0] ns_in_busy;
    logic [num_ports-1:0] sp_ok;

    genvar i, k;

    for (i = 0; i < num_ports; i++) begin : g_port
        // squeeze out the port's own output bit
        for (k = 0; k < num_dests; k++) begin : g_rel
            if (k < i) begin : g_below
                assign ns_out_rel[i][k] = ns_out_busy[k];
            end else begin : g_above
                assign ns_out_rel[i][k] = ns_out_busy[k+1];
            end
        end

        // input side conflict
        assign ns_in_busy[i] = |ns_dest_grant[i];

        // busy input blocks everything, otherwise only free outputs
        assign sp_free[i]   = ns_in_busy[i] ? '0 : ~ns_out_rel[i];
        assign sp_accept[i] = sp_free[i] & sp_dest_grant[i];
        assign sp_ok[i]     = |sp_accept[i];

        // both paths never hold the same port at once, so OR merges them
        assign grant[i].ivc_grant  = ns_ivc_grant[i] | (sp_ok[i] ? sp_ivc_grant[i] : '0);
        assign grant[i].dest_grant = ns_dest_grant[i] | sp_accept[i];
        assign grant[i].spec       = sp_ok[i];
    end

endmodule

// ==== hw/spec_sw_alloc.sv ====
`timescale 1ns/100ps

module spec_sw_alloc import swa_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  req_all_t   req,
    output grant_all_t grant
);

    // request classes
    vc_mask_t   [num_ports-1:0] ns_req;
    vc_mask_t   [num_ports-1:0] sp_req;
    // destinations are shared by both allocators
    vc_dest_t   [num_ports-1:0] port_dest;

    // non-speculative results
    vc_mask_t   [num_ports-1:0] ns_ivc_grant;
    dest_mask_t [num_ports-1:0] ns_dest_grant;
    logic       [num_ports-1:0] ns_out_busy;

    // speculative results, before filtering
    vc_mask_t   [num_ports-1:0] sp_ivc_grant;
    dest_mask_t [num_ports-1:0] sp_dest_grant;

    genvar i;

    for (i = 0; i < num_ports; i++) begin : g_split
        // owns an output vc with room
        assign ns_req[i] = req[i].request & req[i].ovc_assigned & req[i].ovc_not_full;
        // still waiting on vc allocation, masked by speculation valid
        assign sp_req[i] = req[i].request & req[i].spec_valid & ~req[i].ovc_assigned;
        assign port_dest[i] = req[i].dest;
    end

    separable_sw_alloc nonspec_alloc (
        .clk        (clk),
        .reset      (reset),
        .vc_req     (ns_req),
        .dest       (port_dest),
        .ivc_grant  (ns_ivc_grant),
        .dest_grant (ns_dest_grant),
        .out_busy   (ns_out_busy)
    );

    // its own pointers move on its raw grants, filtered or not
    separable_sw_alloc spec_alloc (
        .clk        (clk),
        .reset      (reset),
        .vc_req     (sp_req),
        .dest       (port_dest),
        .ivc_grant  (sp_ivc_grant),
        .dest_grant (sp_dest_grant),
        .out_busy   ()
    );

    // drop colliding speculative grants and merge
    spec_conflict_filter conflict_filter (
        .ns_ivc_grant  (ns_ivc_grant),
        .ns_dest_grant (ns_dest_grant),
        .ns_out_busy   (ns_out_busy),
        .sp_ivc_grant  (sp_ivc_grant),
        .sp_dest_grant (sp_dest_grant),
        .grant         (grant)
    );

endmodule

// ==== verif/spec_sw_alloc_assertions.sv ====
`timescale 1ns/100ps

module spec_sw_alloc_assertions import swa_pkg::*; (
    input logic       clk,
    input logic       reset,
    input grant_all_t grant
);

    // per output port, the input ports that hold it
    logic [num_ports-1:0][num_ports-1:0] out_claims;

    always_comb begin
        out_claims = '0;
        for (int o = 0; o < num_ports; o++) begin
            for (int j = 0; j < num_ports; j++) begin
                if (j != o) begin
                    out_claims[o][j] = grant[j].dest_grant[(o < j) ? o : o - 1];
                end
            end
        end
    end

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        ivc_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(grant[p].ivc_grant))
            else $error("input port %0d granted more than one vc", p);

        dest_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(grant[p].dest_grant))
            else $error("input port %0d granted more than one output", p);

        // a vc grant always comes with an output
        grant_paired: assert property (@(posedge clk) disable iff (reset)
            (|grant[p].ivc_grant) == (|grant[p].dest_grant))
            else $error("input port %0d has a vc grant without an output or the reverse", p);

        out_single: assert property (@(posedge clk) disable iff (reset)
            $onehot0(out_claims[p]))
            else $error("output port %0d granted to more than one input", p);
    end

endmodule

// ==== verif/swa_ref_model.svh ====
`ifndef SWA_REF_MODEL_SVH
`define SWA_REF_MODEL_SVH

// pointer copies, first index 0 for the non-speculative allocator, 1 for the speculative one
int in_ptr  [2][num_ports];
int out_ptr [2][num_ports];

// every pointer back to position 0
task automatic reset_model();
    for (int a = 0; a < 2; a++) begin
        for (int p = 0; p < num_ports; p++) begin
            in_ptr[a][p]  = 0;
            out_ptr[a][p] = 0;
        end
    end
endtask

// first requester at or after ptr going round the circle, -1 when idle
function automatic int pick_round_robin(input logic [num_vcs-1:0] rq, input int ptr,
                                        input int n);
    int pick;
    int idx;
    pick = -1;
    for (int k = n - 1; k >= 0; k--) begin
        idx = (ptr + k) % n;
        // walking downwards leaves the closest one last
        if (rq[idx]) begin
            pick = idx;
        end
    end
    return pick;
endfunction

// relative destination bit of an input back to an absolute output port
function automatic int dest_to_port(input int in_port, input dest_mask_t m);
    int port;
    port = -1;
    for (int k = 0; k < num_dests; k++) begin
        if (m[k]) begin
            port = (k < in_port) ? k : k + 1;
        end
    end
    return port;
endfunction

// one two-level separable allocation, pointers move as the hardware does
task automatic run_separable(input int sel, input vc_mask_t [num_ports-1:0] vreq,
                             input req_all_t r, output vc_mask_t [num_ports-1:0] ivc,
                             output dest_mask_t [num_ports-1:0] dg,
                             output logic [num_ports-1:0] busy);
    int win  [num_ports];
    int want [num_ports];
    int pos;
    int j;
    dest_mask_t oreq;
    ivc  = '0;
    dg   = '0;
    busy = '0;
    // input stage
    for (int i = 0; i < num_ports; i++) begin
        win[i]  = pick_round_robin(vreq[i], in_ptr[sel][i], num_vcs);
        want[i] = -1;
        if (win[i] >= 0) begin
            want[i] = dest_to_port(i, r[i].dest[win[i]]);
        end
    end
    // output stage, requesters seen without the output's own port
    for (int o = 0; o < num_ports; o++) begin
        oreq = '0;
        for (int i = 0; i < num_ports; i++) begin
            if (i != o && want[i] == o) begin
                oreq[(i < o) ? i : i - 1] = 1'b1;
            end
        end
        pos = pick_round_robin(oreq, out_ptr[sel][o], num_dests);
        if (pos >= 0) begin
            j = (pos < o) ? pos : pos + 1;
            busy[o] = 1'b1;
            ivc[j][win[j]] = 1'b1;
            dg[j][(o < j) ? o : o - 1] = 1'b1;
            out_ptr[sel][o] = (pos + 1) % num_dests;
        end
    end
    // input pointers only move for ports that won an output
    for (int i = 0; i < num_ports; i++) begin
        if (dg[i] != '0) begin
            in_ptr[sel][i] = (win[i] + 1) % num_vcs;
        end
    end
endtask

// expected merged grant of one cycle
task automatic predict_grants(input req_all_t r, output grant_all_t exp);
    vc_mask_t   [num_ports-1:0] ns_req;
    vc_mask_t   [num_ports-1:0] sp_req;
    vc_mask_t   [num_ports-1:0] ns_ivc;
    vc_mask_t   [num_ports-1:0] sp_ivc;
    dest_mask_t [num_ports-1:0] ns_dst;
    dest_mask_t [num_ports-1:0] sp_dst;
    logic       [num_ports-1:0] ns_busy;
    logic       [num_ports-1:0] sp_busy;
    int o;
    for (int p = 0; p < num_ports; p++) begin
        // owns an output vc with space
        ns_req[p] = r[p].request & r[p].ovc_assigned & r[p].ovc_not_full;
        // waits for an output vc and may speculate
        sp_req[p] = r[p].request & r[p].spec_valid & ~r[p].ovc_assigned;
    end
    run_separable(0, ns_req, r, ns_ivc, ns_dst, ns_busy);
    run_separable(1, sp_req, r, sp_ivc, sp_dst, sp_busy);
    for (int p = 0; p < num_ports; p++) begin
        exp[p].ivc_grant  = ns_ivc[p];
        exp[p].dest_grant = ns_dst[p];
        exp[p].spec       = 1'b0;
        o = dest_to_port(p, sp_dst[p]);
        // speculative win kept only with both its ports untouched
        if (o >= 0 && ns_dst[p] == '0 && !ns_busy[o]) begin
            exp[p].ivc_grant  = sp_ivc[p];
            exp[p].dest_grant = sp_dst[p];
            exp[p].spec       = 1'b1;
        end
    end
endtask

`endif

// ==== verif/tb_spec_sw_alloc.sv ====
`timescale 1ns/100ps

module tb_spec_sw_alloc import swa_pkg::*; ();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int num_cycles   = 2000;
    localparam int idle_cycles  = 4;
    // phase bounds for non-speculative only and speculative only traffic
    // mixed traffic after that
    localparam int ns_only_end   = 600;
    localparam int spec_only_end = 1200;

    logic       clk;
    logic       reset;
    req_all_t   req;
    grant_all_t grant;
    integer     seed;

    `include "swa_ref_model.svh"

    spec_sw_alloc dut_i (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .grant (grant)
    );

    bind spec_sw_alloc spec_sw_alloc_assertions grant_checks (
        .clk   (clk),
        .reset (reset),
        .grant (grant)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // whole grant bundle of one port
    task automatic check_grant(input string name, input port_grant_t got,
                               input port_grant_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // winning vc of one port
    task automatic check_ivc(input string name, input vc_mask_t got, input vc_mask_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // new random request set with the class mix of its phase
    task automatic make_req(input int n, output req_all_t r);
        for (int p = 0; p < num_ports; p++) begin
            r[p].request      = vc_mask_t'($random(seed));
            // mostly room downstream
            r[p].ovc_not_full = vc_mask_t'($random(seed) | $random(seed));
            r[p].spec_valid   = vc_mask_t'($random(seed));
            if (n < ns_only_end) begin
                r[p].ovc_assigned = '1;
            end else if (n < spec_only_end) begin
                r[p].ovc_assigned = '0;
            end else begin
                r[p].ovc_assigned = vc_mask_t'($random(seed));
            end
            // one other port per vc
            for (int v = 0; v < num_vcs; v++) begin
                r[p].dest[v] = dest_mask_t'(1) << ($random(seed) & 3);
            end
        end
    endtask

    // sampled mid cycle
    // model pointers move after the prediction
    task automatic check_cycle();
        grant_all_t expected;
        predict_grants(req, expected);
        for (int p = 0; p < num_ports; p++) begin
            check_ivc($sformatf("grant[%0d].ivc_grant", p), grant[p].ivc_grant,
                      expected[p].ivc_grant);
            check_grant($sformatf("grant[%0d]", p), grant[p], expected[p]);
        end
    endtask

    initial begin
        req_all_t next_req;
        clk         = 1'b0;
        reset       = 1'b1;
        req         = '0;
        seed        = 72;
        next_req    = '0;
        reset_model();
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        // no requests after reset so every grant stays low
        repeat (idle_cycles) begin
            @(negedge clk);
            check_cycle();
        end
        for (int n = 0; n < num_cycles; n++) begin
            @(posedge clk);
            // last 4 of every 16 cycles repeat the request
            // winners rotate through the pointers
            if ((n % 16) < 12) begin
                make_req(n, next_req);
            end
            req <= next_req;
            @(negedge clk);
            check_cycle();
        end
        $display(">>> PASS");
        $finish;
    end

    // watchdog over reset and test length plus margin
    initial begin
        #((reset_cycles + num_cycles + 100) * clk_period);
        $display("watchdog expired, the test did not finish in time");
        stop_with_failure();
    end

endmodule

// ==== list.f ====
+incdir+verif
hw/swa_pkg.sv
hw/rr_arbiter.sv
hw/separable_sw_alloc.sv
hw/spec_conflict_filter.sv
hw/spec_sw_alloc.sv
verif/spec_sw_alloc_assertions.sv
verif/tb_spec_sw_alloc.sv

// ==== run.sh ====
#!/bin/sh
# build and run the switch allocator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_spec_sw_alloc -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
